// ==== sources.f ====
+incdir+src
src/emu_timing_pkg.sv
src/emu_sbit_pkg.sv
src/bx_timing_if.sv
src/bx_timing.sv
src/sbit_pattern_gen.sv
src/tap_delay_line.sv
src/vfat_lane.sv
src/sbit_emulator_top.sv
tb/sbit_emulator_checker.sv
tb/sbit_emulator_tb.sv

// ==== Bender.yml ====
package:
  name: sbit_emulator

export_include_dirs:
  - src

sources:
  - files:
      - src/emu_timing_pkg.sv
      - src/emu_sbit_pkg.sv
      - src/bx_timing_if.sv
      - src/bx_timing.sv
      - src/sbit_pattern_gen.sv
      - src/tap_delay_line.sv
      - src/vfat_lane.sv
      - src/sbit_emulator_top.sv
  - target: test
    files:
      - tb/sbit_emulator_checker.sv
      - tb/sbit_emulator_tb.sv

// ==== tb/sbit_emulator_tb.sv ====
`timescale 1ns/1ps

module sbit_emulator_tb;

  localparam int RESET_CYCLES   = 16;
  localparam int RUN_CYCLES     = 2100; // four orbits, both tap values twice
  localparam int SWAP_CYCLE     = 1300; // new random stimulus from here on
  localparam int TIMEOUT_CYCLES = 2600; // reset + run + margin

  logic        clk40;
  logic        reset_i;
  logic [31:0] pat_even_i;
  logic [31:0] pat_odd_i;
  logic [31:0] invert_mask_i;
  logic [31:0] sbits_o;
  logic        bc0_o;
  logic        startup_done_o;
  int          tick_cnt; // every cycle, reset included
  int          errors;

  sbit_emulator_top u_dut (
    .clk40          (clk40),
    .reset_i        (reset_i),
    .pat_even_i     (pat_even_i),
    .pat_odd_i      (pat_odd_i),
    .invert_mask_i  (invert_mask_i),
    .sbits_o        (sbits_o),
    .bc0_o          (bc0_o),
    .startup_done_o (startup_done_o)
  );

  // assertions sit inside the dut
  bind sbit_emulator_top sbit_emulator_checker u_chk (.*);

  // ----------------------------------------
  // clock and timeout
  // ----------------------------------------
  initial begin
    clk40    = 1'b0;
    tick_cnt = 0;
  end

  always #5 clk40 = ~clk40; // 10 ns period

  always @(posedge clk40) begin
    tick_cnt <= tick_cnt + 1;
    if (tick_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // fresh even, odd and mask words
  task automatic draw_stimulus();
    pat_even_i    <= $urandom;
    pat_odd_i     <= $urandom;
    invert_mask_i <= $urandom;
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    void'($urandom(74)); // one seed for the run
    reset_i       = 1'b1;
    pat_even_i    = 32'h000000fe;
    pat_odd_i     = 32'h00000001;
    invert_mask_i = 32'he7466745;
    repeat (RESET_CYCLES) @(posedge clk40);
    reset_i <= 1'b0;
    for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
      @(posedge clk40);
      if (cyc + 1 == SWAP_CYCLE) begin
        draw_stimulus(); // visible from cycle SWAP_CYCLE
      end
    end
    @(negedge clk40); // half a bx after the last checked edge
    errors = u_dut.u_chk.err_cnt;
    if (u_dut.u_chk.data_chk_cnt == 0) begin
      $display("no s-bit data compares ran after startup");
      errors++;
    end
    $display("run done: %0d cycles, %0d data checks, %0d errors",
             RUN_CYCLES, u_dut.u_chk.data_chk_cnt, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== tb/sbit_emulator_checker.sv ====
`timescale 1ns/1ps
`include "emu_params.svh"

module sbit_emulator_checker (
  input logic        clk40,
  input logic        reset_i,
  input logic [31:0] pat_even_i,
  input logic [31:0] pat_odd_i,
  input logic [31:0] invert_mask_i,
  input logic [31:0] sbits_o,
  input logic        bc0_o,
  input logic        startup_done_o
);

  localparam int unsigned SKIP = `EMU_TAP_DEPTH + 3; // longest lag after a tap step

  int          err_cnt      = 0;
  int          data_chk_cnt = 0;             // sbit compares that ran
  int unsigned cyc_q;                        // 0 is the first bx out of reset
  logic [31:0] mask_q;                       // mask seen one bx earlier
  logic [31:0] hist_q [`EMU_TAP_DEPTH];      // expected frame per cycle, ring
  logic [31:0] sel_exp;
  int unsigned orbit_tap;
  logic [31:0] lag_frame;
  logic        data_chk;

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  always_comb begin
    sel_exp = '0; // idle slot or still starting up
    if (cyc_q >= `EMU_STARTUP_CYCLES) begin
      case (cyc_q % `EMU_NUM_SLOTS)
        0:       sel_exp = pat_even_i;
        1:       sel_exp = pat_odd_i;
        default: sel_exp = '0;
      endcase
    end
  end

  // tap steps once per orbit, wraps at the line depth
  assign orbit_tap = (cyc_q / `EMU_BC0_PERIOD * `EMU_TAP_STEP) % `EMU_TAP_DEPTH;
  assign lag_frame = hist_q[(cyc_q - 3 - orbit_tap) % `EMU_TAP_DEPTH]; // 3 bx pipe + tap
  // after a step the lines still show frames picked under the old tap
  assign data_chk  = !reset_i && (cyc_q >= `EMU_STARTUP_CYCLES)
                     && ((cyc_q % `EMU_BC0_PERIOD) > SKIP);

  always_ff @(posedge clk40) begin
    mask_q                         <= invert_mask_i;
    hist_q[cyc_q % `EMU_TAP_DEPTH] <= sel_exp;
    if (reset_i) begin
      cyc_q <= 0;
    end else begin
      cyc_q <= cyc_q + 1;
    end
    if (data_chk) begin
      data_chk_cnt <= data_chk_cnt + 1;
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------
  a_bc0: assert property (@(posedge clk40)
    !reset_i |-> (bc0_o == ((cyc_q + 1) % `EMU_BC0_PERIOD == 0)))
    else begin
      $error("CHECK FAILED t=%0t: bc0_o off the last bx of the orbit", $time);
      err_cnt++;
    end

  a_startup: assert property (@(posedge clk40)
    !reset_i |-> (startup_done_o == (cyc_q >= `EMU_STARTUP_CYCLES)))
    else begin
      $error("CHECK FAILED t=%0t: startup_done_o wrong for this cycle", $time);
      err_cnt++;
    end

  // lines full of zeros, only the mask shows
  a_quiet: assert property (@(posedge clk40)
    (!reset_i && cyc_q >= `EMU_TAP_DEPTH && cyc_q < `EMU_STARTUP_CYCLES)
      |-> (sbits_o == mask_q))
    else begin
      $error("CHECK FAILED t=%0t: sbits_o not the bare mask during startup", $time);
      err_cnt++;
    end

  a_tap0: assert property (@(posedge clk40)
    (data_chk && orbit_tap == 0) |-> ((sbits_o ^ mask_q) == lag_frame))
    else begin
      $error("CHECK FAILED t=%0t: sbits_o wrong at tap 0", $time);
      err_cnt++;
    end

  a_tap_step: assert property (@(posedge clk40)
    (data_chk && orbit_tap == `EMU_TAP_STEP) |-> ((sbits_o ^ mask_q) == lag_frame))
    else begin
      $error("CHECK FAILED t=%0t: sbits_o wrong after the tap step", $time);
      err_cnt++;
    end

endmodule

// ==== src/sbit_emulator_top.sv ====
`timescale 1ns/1ps
`include "emu_params.svh"

module sbit_emulator_top
  import emu_sbit_pkg::*;
(
  input  logic                                          clk40,
  input  logic                                          reset_i,
  input  logic [`EMU_NUM_VFATS*`EMU_SBITS_PER_VFAT-1:0] pat_even_i,
  input  logic [`EMU_NUM_VFATS*`EMU_SBITS_PER_VFAT-1:0] pat_odd_i,
  input  logic [`EMU_NUM_VFATS*`EMU_SBITS_PER_VFAT-1:0] invert_mask_i,
  output logic [`EMU_NUM_VFATS*`EMU_SBITS_PER_VFAT-1:0] sbits_o,
  output logic                                          bc0_o,
  output logic                                          startup_done_o
);

  // ----------------------------------------
  // flat ports onto vfat frames
  // ----------------------------------------
  sbit_bus_t pat_even;
  sbit_bus_t pat_odd;
  sbit_bus_t invert_mask;
  sbit_bus_t pat_frame;   // selected pattern, one bx late
  sbit_bus_t sbits;

  assign pat_even    = pat_even_i;
  assign pat_odd     = pat_odd_i;
  assign invert_mask = invert_mask_i; // bit n flips s-bit n

  // ----------------------------------------
  // timing
  // ----------------------------------------
  bx_timing_if timing_if ();

  bx_timing u_timing (
    .clk40   (clk40),
    .reset_i (reset_i),
    .timing  (timing_if.timing_mp)
  );

  // ----------------------------------------
  // pattern source
  // ----------------------------------------
  sbit_pattern_gen u_pattern (
    .clk40      (clk40),
    .reset_i    (reset_i),
    .timing     (timing_if.pattern_mp),
    .pat_even_i (pat_even),
    .pat_odd_i  (pat_odd),
    .frame_o    (pat_frame)
  );

  // ----------------------------------------
  // per vfat delay and inversion
  // ----------------------------------------
  for (genvar v = 0; v < `EMU_NUM_VFATS; v++) begin : g_vfat
    vfat_lane u_lane (
      .clk40    (clk40),
      .reset_i  (reset_i),
      .timing   (timing_if.lane_mp),
      .frame_i  (pat_frame[v]),
      .invert_i (invert_mask[v]),
      .frame_o  (sbits[v])
    );
  end

  assign sbits_o        = sbits;
  assign bc0_o          = timing_if.bc0;          // orbit marker out
  assign startup_done_o = timing_if.startup_done;

endmodule

// ==== src/vfat_lane.sv ====
`timescale 1ns/1ps

module vfat_lane
  import emu_sbit_pkg::*;
(
  input  logic         clk40,
  input  logic         reset_i,
  bx_timing_if.lane_mp timing,
  input  vfat_frame_t  frame_i,  // undelayed s-bits of this vfat
  input  vfat_frame_t  invert_i, // 1 flips the pin polarity
  output vfat_frame_t  frame_o
);

  vfat_frame_t dly_bits; // delay line outputs

  // ----------------------------------------
  // one delay line per s-bit
  // ----------------------------------------
  for (genvar i = 0; i < $bits(vfat_frame_t); i++) begin : g_bit
    tap_delay_line u_dly (
      .clk40 (clk40),
      .bit_i (frame_i[i]),
      .tap_i (timing.tap), // same tap on every pin
      .bit_o (dly_bits[i])
    );
  end

  // polarity swap as on the board pairs, then register
  always_ff @(posedge clk40) begin
    if (reset_i) begin
      frame_o <= '0;
    end else begin
      frame_o <= dly_bits ^ invert_i;
    end
  end

endmodule

// ==== src/tap_delay_line.sv ====
`timescale 1ns/1ps
`include "emu_params.svh"

module tap_delay_line
  import emu_timing_pkg::*;
#(
  parameter int DEPTH = `EMU_TAP_DEPTH // power of two
) (
  input  logic clk40,
  input  logic bit_i,
  input  tap_t tap_i,
  output logic bit_o
);

  localparam int SEL_W = $clog2(DEPTH);

  logic [DEPTH-1:0] sr_q; // element 0 holds the newest bit
  logic [SEL_W-1:0] sel;

  // tap fits the depth, extended or cut as needed
  assign sel = SEL_W'(tap_i);

  // shift every bx, srl style
  always_ff @(posedge clk40) begin
    sr_q <= {sr_q[DEPTH-2:0], bit_i};
  end

  assign bit_o = sr_q[sel]; // tap d gives d+1 bx of delay

endmodule

// ==== src/sbit_pattern_gen.sv ====
`timescale 1ns/1ps

module sbit_pattern_gen
  import emu_timing_pkg::*;
  import emu_sbit_pkg::*;
(
  input  logic            clk40,
  input  logic            reset_i,
  bx_timing_if.pattern_mp timing,
  input  sbit_bus_t       pat_even_i, // sent in the even slot
  input  sbit_bus_t       pat_odd_i,  // sent in the odd slot
  output sbit_bus_t       frame_o
);

  sbit_bus_t sel_pat;

  // ----------------------------------------
  // slot select
  // ----------------------------------------
  always_comb begin
    sel_pat = '0; // idle slots and link startup stay quiet
    if (timing.startup_done) begin
      case (timing.slot_kind)
        SLOT_EVEN: sel_pat = pat_even_i;
        SLOT_ODD:  sel_pat = pat_odd_i;
        default:   sel_pat = '0;
      endcase
    end
  end

  // one bx of latency
  always_ff @(posedge clk40) begin
    if (reset_i) begin
      frame_o <= '0;
    end else begin
      frame_o <= sel_pat;
    end
  end

endmodule

// ==== src/bx_timing.sv ====
`timescale 1ns/1ps
`include "emu_params.svh"

module bx_timing
  import emu_timing_pkg::*;
(
  input  logic           clk40,
  input  logic           reset_i,
  bx_timing_if.timing_mp timing
);

  localparam int START_W = $clog2(`EMU_STARTUP_CYCLES);
  localparam int BC0_W   = $clog2(`EMU_BC0_PERIOD);

  logic [START_W-1:0] startup_cnt;
  logic               startup_done_q;
  logic [BC0_W-1:0]   bc0_cnt;        // position in the orbit
  logic               bc0_q;
  slot_phase_t        phase_q;
  slot_kind_e         slot_kind_q;
  tap_t               tap_q;

  // phase 0 even, phase 1 odd, rest idle
  function automatic slot_kind_e phase_to_kind(slot_phase_t ph);
    slot_kind_e kind;
    case (ph)
      slot_phase_t'(0): kind = SLOT_EVEN;
      slot_phase_t'(1): kind = SLOT_ODD;
      default:          kind = SLOT_IDLE;
    endcase
    return kind;
  endfunction

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk40) begin
    if (reset_i) begin
      startup_cnt    <= '0;
      startup_done_q <= 1'b0;
      bc0_cnt        <= '0;
      bc0_q          <= 1'b0;
      phase_q        <= '0;
      slot_kind_q    <= SLOT_EVEN; // phase 0 in the first bx
      tap_q          <= '0;
    end else begin
      if (!startup_done_q) begin
        startup_cnt <= startup_cnt + 1'b1; // freezes once done
        if (startup_cnt == START_W'(`EMU_STARTUP_CYCLES - 1)) begin
          startup_done_q <= 1'b1;
        end
      end
      // flag one early so the registered pulse sits on the last bx of the orbit
      bc0_q <= (bc0_cnt == BC0_W'(`EMU_BC0_PERIOD - 2));
      if (bc0_cnt == BC0_W'(`EMU_BC0_PERIOD - 1)) begin
        bc0_cnt <= '0;
      end else begin
        bc0_cnt <= bc0_cnt + 1'b1;
      end
      phase_q     <= phase_q + 1'b1;                // wraps at slot count
      slot_kind_q <= phase_to_kind(phase_q + 1'b1); // kind of the next phase
      if (bc0_q) begin
        tap_q <= tap_q + tap_t'(`EMU_TAP_STEP); // sweep, modulo depth
      end
    end
  end

  assign timing.startup_done = startup_done_q;
  assign timing.bc0          = bc0_q;
  assign timing.slot_kind    = slot_kind_q;
  assign timing.tap          = tap_q;

endmodule

// ==== src/bx_timing_if.sv ====
`timescale 1ns/1ps

interface bx_timing_if;

  logic                       startup_done; // level, stays high after startup
  logic                       bc0;          // one bx pulse per orbit
  emu_timing_pkg::slot_kind_e slot_kind;    // kind of the current slot
  emu_timing_pkg::tap_t       tap;          // common tap for all delay lines

  // counter block drives everything
  modport timing_mp (
    output startup_done,
    output bc0,
    output slot_kind,
    output tap
  );

  modport pattern_mp (input startup_done, input slot_kind);

  modport lane_mp (input tap);

endinterface

// ==== src/emu_sbit_pkg.sv ====
`include "emu_params.svh"

package emu_sbit_pkg;

  // ----------------------------------------
  // s-bit data
  // ----------------------------------------

  // all s-bits of one vfat in one crossing
  typedef logic [`EMU_SBITS_PER_VFAT-1:0] vfat_frame_t;

  // every vfat side by side, vfat 0 in the low byte
  typedef vfat_frame_t [`EMU_NUM_VFATS-1:0] sbit_bus_t;

endpackage

// ==== src/emu_timing_pkg.sv ====
`include "emu_params.svh"

package emu_timing_pkg;

  // position inside the repeating slot cycle
  typedef logic [$clog2(`EMU_NUM_SLOTS)-1:0] slot_phase_t;

  // what a bunch crossing slot carries
  typedef enum logic [1:0] {
    SLOT_EVEN = 2'd0, // first crossing, even pattern
    SLOT_ODD  = 2'd1, // next crossing, odd pattern
    SLOT_IDLE = 2'd2  // nothing sent, keeps latency easy to see
  } slot_kind_e;

  // selected tap of the delay lines
  typedef logic [$clog2(`EMU_TAP_DEPTH)-1:0] tap_t;

endpackage

// ==== src/emu_params.svh ====
`ifndef EMU_PARAMS_SVH
`define EMU_PARAMS_SVH

// ----------------------------------------
// emulator geometry
// ----------------------------------------
// vfats driven by the emulator
`define EMU_NUM_VFATS      4
// s-bits in one vfat frame
`define EMU_SBITS_PER_VFAT 8

// ----------------------------------------
// timing
// ----------------------------------------
`define EMU_TAP_DEPTH      64   // taps per delay line, power of two
`define EMU_TAP_STEP       32   // tap sweep per orbit
`define EMU_BC0_PERIOD     512  // orbit length in bx
`define EMU_STARTUP_CYCLES 600  // quiet time while the link comes up
`define EMU_NUM_SLOTS      8    // even, odd, then idle slots

`endif
